/* Bender.yml */
package:
  name: xalu

sources:
  - src/xalu_pkg.sv
  - src/xalu_in_fifo.sv
  - src/xalu_mul_shf.sv
  - src/xalu_div.sv
  - src/xalu_result_buf.sv
  - src/xalu_if.sv
  - target: test
    files:
      - testbench/tb_xalu.sv

/* src/xalu_div.sv */
// iterative restoring divider, signed and unsigned
// setup, DATA_W shift-subtract steps, sign fix, hold until ack

`timescale 1ns/1ps
`default_nettype none

module xalu_div (
  input  bit                       gclk,
  input  bit                       rst,
  input  bit                       rd_valid,
  input  xalu_pkg::xalu_req_t      rd_req,
  output bit                       rd_en,
  input  bit                       div_ack,   // result table took the write
  output bit                       done,
  output bit [xalu_pkg::TID_W-1:0] done_tid,
  output xalu_pkg::xalu_res_t      done_res
);

  localparam int W     = xalu_pkg::DATA_W;
  localparam int CNT_W = $clog2(W);

  typedef enum logic [1:0] {s_idle, s_run, s_fix, s_hold} div_state_e;

  div_state_e          state;
  xalu_pkg::xalu_word_t quo;   // dividend shifts out, quotient shifts in
  xalu_pkg::xalu_word_t rem;   // partial remainder
  xalu_pkg::xalu_word_t dvs;   // divisor magnitude
  logic [CNT_W-1:0]    cnt;
  logic                neg_q, neg_r, ovf;
  logic                sgn_div;
  xalu_pkg::xalu_word_t mag1, mag2;
  logic [W:0]          trial;  // extra bit is the borrow
  xalu_pkg::xalu_word_t q_fix, r_fix;

  assign rd_en   = (state == s_idle) && rd_valid;  // pop only when idle
  assign done    = (state == s_hold);
  assign sgn_div = (rd_req.op == xalu_pkg::op_sdiv);
  assign mag1    = (sgn_div && rd_req.op1[W-1]) ? -rd_req.op1 : rd_req.op1;
  assign mag2    = (sgn_div && rd_req.op2[W-1]) ? -rd_req.op2 : rd_req.op2;
  assign trial   = {rem, quo[W-1]} - {1'b0, dvs};
  assign q_fix   = neg_q ? -quo : quo;
  assign r_fix   = neg_r ? -rem : rem;  // remainder follows op1 sign

  // ----------------------------------------------------------
  // control FSM
  // ----------------------------------------------------------
  always_ff @(posedge gclk) begin
    if (rst) begin
      state <= s_idle;
    end else begin
      case (state)
        s_idle: if (rd_en) state <= s_run;
        s_run:  if (cnt == CNT_W'(W - 1)) state <= s_fix;
        s_fix:  state <= s_hold;
        s_hold: if (div_ack) state <= s_idle;  // wait out mul writebacks
        default: state <= s_idle;
      endcase
    end
  end

  // datapath
  always_ff @(posedge gclk) begin
    case (state)
      s_idle: begin
        quo      <= mag1;
        rem      <= '0;
        dvs      <= mag2;
        cnt      <= '0;
        neg_q    <= sgn_div && (rd_req.op1[W-1] ^ rd_req.op2[W-1]);
        neg_r    <= sgn_div && rd_req.op1[W-1];
        ovf      <= sgn_div && (rd_req.op1 == {1'b1, {(W-1){1'b0}}}) && (&rd_req.op2);
        done_tid <= rd_req.tid;
      end
      s_run: begin
        if (!trial[W]) begin  // no borrow, keep the difference
          rem <= trial[W-1:0];
          quo <= {quo[W-2:0], 1'b1};
        end else begin
          rem <= {rem[W-2:0], quo[W-1]};
          quo <= {quo[W-2:0], 1'b0};
        end
        cnt <= cnt + 1'b1;
      end
      s_fix: begin
        done_res.res <= q_fix;  // min / -1 already yields min here
        done_res.y   <= r_fix;
        done_res.n   <= q_fix[W-1];
        done_res.z   <= (q_fix == '0);
        done_res.v   <= ovf;
      end
      default: ;  // hold keeps the result
    endcase
  end

  // divide by zero is filtered at request decode
  a_no_zero_div : assert property (@(posedge gclk) disable iff (rst) rd_en |-> (rd_req.op2 != '0));

endmodule

`default_nettype wire

/* src/xalu_if.sv */
// extended alu front end, top level
// request decode, mul/div FIFOs and units, result table
// output pipeline register, replay and divide-by-zero signalling

`timescale 1ns/1ps
`default_nettype none

module xalu_if #(
  parameter int NTHREAD = 8
) (
  input  bit                       gclk,
  input  bit                       rst,
  input  bit                       in_valid,
  input  bit                       in_replay,  // 1: collect attempt
  input  bit [xalu_pkg::TID_W-1:0] in_tid,
  input  xalu_pkg::xalu_op_e       in_op,
  input  xalu_pkg::xalu_word_t     in_op1,
  input  xalu_pkg::xalu_word_t     in_op2,
  output bit                       out_valid,
  output bit                       out_divz,
  output bit                       new_replay,
  output xalu_pkg::xalu_res_t      out_res
);

  xalu_pkg::xalu_req_t        req;
  logic                       new_req, is_mul, is_div, op2_zero;
  logic                       mul_wr, div_wr, divz;
  logic                       mul_rd_valid, mul_rd_en, div_rd_valid, div_rd_en;
  xalu_pkg::xalu_req_t        mul_req, div_req;
  logic                       mul_done, div_done, div_ack;
  logic [xalu_pkg::TID_W-1:0] mul_tid, div_tid;
  xalu_pkg::xalu_res_t        mul_res, div_res, buf_res;
  logic                       buf_ready;
  logic                       s2_valid, s2_replay, s2_divz, s2_ready;  // stage two

  // ----------------------------------------------------------
  // stage one, request decode
  // ----------------------------------------------------------
  assign req      = '{tid: in_tid, op: in_op, op1: in_op1, op2: in_op2};
  assign new_req  = in_valid && !in_replay;
  assign op2_zero = (in_op2 == '0);

  always_comb begin
    is_mul = 1'b0;
    is_div = 1'b0;
    case (in_op)
      xalu_pkg::op_umul, xalu_pkg::op_smul, xalu_pkg::op_sll,
      xalu_pkg::op_srl, xalu_pkg::op_sra:   is_mul = 1'b1;
      xalu_pkg::op_udiv, xalu_pkg::op_sdiv: is_div = 1'b1;
      default: ;
    endcase
  end

  assign mul_wr = new_req && is_mul;
  assign div_wr = new_req && is_div && !op2_zero;  // div by zero never queued
  assign divz   = new_req && is_div && op2_zero;

  // ----------------------------------------------------------
  // stage two, output register
  // ----------------------------------------------------------
  always_ff @(posedge gclk) begin
    if (rst) begin
      s2_valid  <= 1'b0;
      s2_replay <= 1'b0;
      s2_divz   <= 1'b0;
      s2_ready  <= 1'b0;
    end else begin
      s2_valid  <= in_valid;
      s2_replay <= in_replay;
      s2_divz   <= divz;
      s2_ready  <= buf_ready;  // ready bit as seen in the input cycle
    end
  end

  always_ff @(posedge gclk) begin
    out_res <= buf_res;
  end

  assign out_valid  = s2_valid && s2_replay && s2_ready;
  assign out_divz   = s2_valid && s2_divz;
  assign new_replay = s2_valid && (s2_replay ? !s2_ready : !s2_divz);

  xalu_in_fifo #(.NTHREAD(NTHREAD)) mul_fifo (
    .gclk, .rst, .wr_en(mul_wr), .wr_req(req),
    .rd_en(mul_rd_en), .rd_valid(mul_rd_valid), .rd_req(mul_req)
  );

  xalu_in_fifo #(.NTHREAD(NTHREAD)) div_fifo (
    .gclk, .rst, .wr_en(div_wr), .wr_req(req),
    .rd_en(div_rd_en), .rd_valid(div_rd_valid), .rd_req(div_req)
  );

  xalu_mul_shf mul_unit (
    .gclk, .rst, .rd_valid(mul_rd_valid), .rd_req(mul_req), .rd_en(mul_rd_en),
    .done(mul_done), .done_tid(mul_tid), .done_res(mul_res)
  );

  xalu_div div_unit (
    .gclk, .rst, .rd_valid(div_rd_valid), .rd_req(div_req), .rd_en(div_rd_en),
    .div_ack, .done(div_done), .done_tid(div_tid), .done_res(div_res)
  );

  xalu_result_buf #(.NTHREAD(NTHREAD)) res_buf (
    .gclk, .rst, .clr_en(new_req), .clr_tid(in_tid),
    .mul_done, .mul_tid, .mul_res,
    .div_done, .div_tid, .div_res, .div_ack,
    .rd_tid(in_tid), .rd_ready(buf_ready), .rd_res(buf_res)
  );

  // a request lands in at most one queue
  a_one_fifo_wr : assert property (@(posedge gclk) disable iff (rst) !(mul_wr && div_wr));

endmodule

`default_nettype wire

/* src/xalu_in_fifo.sv */
// request FIFO, one entry per thread
// circular buffer with head/tail pointers and a last-op-was-read bit

`timescale 1ns/1ps
`default_nettype none

module xalu_in_fifo #(
  parameter int NTHREAD = 8
) (
  input  bit                  gclk,
  input  bit                  rst,
  input  bit                  wr_en,   // push from request decode
  input  xalu_pkg::xalu_req_t wr_req,
  input  bit                  rd_en,   // pop from the unit
  output bit                  rd_valid,
  output xalu_pkg::xalu_req_t rd_req
);

  localparam int PTR_W = $clog2(NTHREAD);

  xalu_pkg::xalu_req_t mem [NTHREAD];  // payload storage
  logic [PTR_W-1:0]    head;           // next entry to read
  logic [PTR_W-1:0]    tail;           // next entry to write
  logic                last_read;      // 1: pointers equal means empty
  logic                full;
  logic                empty;

  assign empty    = (head == tail) && last_read;
  assign full     = (head == tail) && !last_read;
  assign rd_valid = !empty;
  assign rd_req   = mem[head];  // async read of the head entry

  // pointers and full/empty tracking
  always_ff @(posedge gclk) begin
    if (rst) begin
      head      <= '0;
      tail      <= '0;
      last_read <= 1'b1;  // starts empty
    end else begin
      if (wr_en) tail <= tail + 1'b1;  // wraps, depth is a power of two
      if (rd_en) head <= head + 1'b1;
      if (wr_en && !rd_en)
        last_read <= 1'b0;
      else if (rd_en)
        last_read <= 1'b1;
    end
  end

  always_ff @(posedge gclk) begin
    if (wr_en) mem[tail] <= wr_req;
  end

  // one op per thread in flight, so depth NTHREAD is never exceeded
  a_no_overflow : assert property (@(posedge gclk) disable iff (rst) !(wr_en && full));
  a_no_underflow : assert property (@(posedge gclk) disable iff (rst) !(rd_en && empty));

endmodule

`default_nettype wire

/* src/xalu_mul_shf.sv */
// two-stage pipelined multiply / shift unit
// stage one: product or shift result, stage two: result word and flags

`timescale 1ns/1ps
`default_nettype none

module xalu_mul_shf (
  input  bit                             gclk,
  input  bit                             rst,
  input  bit                             rd_valid,  // FIFO not empty
  input  xalu_pkg::xalu_req_t            rd_req,
  output bit                             rd_en,
  output bit                             done,      // one-cycle writeback strobe
  output bit [xalu_pkg::TID_W-1:0]       done_tid,
  output xalu_pkg::xalu_res_t            done_res
);

  localparam int W   = xalu_pkg::DATA_W;
  localparam int SH_W = $clog2(W);

  logic                    s1_valid;
  logic [xalu_pkg::TID_W-1:0] s1_tid;
  logic [2*W-1:0]          s1_val;   // 64-bit product, or shift in the low word
  logic [2*W-1:0]          prod_u;
  logic signed [2*W-1:0]   prod_s;
  logic [SH_W-1:0]         shamt;
  logic [2*W-1:0]          s1_next;
  xalu_pkg::xalu_res_t     s2_res;

  assign rd_en = rd_valid;  // fully pipelined, pop every cycle data is there
  assign shamt = rd_req.op2[SH_W-1:0];

  // ----------------------------------------------------------
  // stage one datapath
  // ----------------------------------------------------------
  always_comb begin
    prod_u = rd_req.op1 * rd_req.op2;                    // 64-bit context
    prod_s = $signed(rd_req.op1) * $signed(rd_req.op2);
    case (rd_req.op)
      xalu_pkg::op_umul: s1_next = prod_u;
      xalu_pkg::op_smul: s1_next = prod_s;
      xalu_pkg::op_sll:  s1_next = {{W{1'b0}}, rd_req.op1 << shamt};
      xalu_pkg::op_srl:  s1_next = {{W{1'b0}}, rd_req.op1 >> shamt};
      xalu_pkg::op_sra:  s1_next = {{W{1'b0}}, W'($signed(rd_req.op1) >>> shamt)};
      default:           s1_next = '0;  // divides never reach this unit
    endcase
  end

  // stage two: y is zero for shifts since the high word is padded
  always_comb begin
    s2_res.res = s1_val[W-1:0];
    s2_res.y   = s1_val[2*W-1:W];
    s2_res.n   = s1_val[W-1];
    s2_res.z   = (s1_val[W-1:0] == '0);
    s2_res.v   = 1'b0;
  end

  // valid bits
  always_ff @(posedge gclk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      done     <= 1'b0;
    end else begin
      s1_valid <= rd_en;
      done     <= s1_valid;
    end
  end

  // payload pipeline
  always_ff @(posedge gclk) begin
    s1_tid   <= rd_req.tid;
    s1_val   <= s1_next;
    done_tid <= s1_tid;
    done_res <= s2_res;
  end

endmodule

`default_nettype wire

/* src/xalu_pkg.sv */
// shared types and widths for the extended alu front end
// operation codes, word, result and queued request formats

`default_nettype none

package xalu_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------
  localparam int DATA_W = 32;  // operand / result width
  localparam int TID_W  = 3;   // thread id width, >= log2 of thread count

  // ----------------------------------------------------------
  // operation codes
  // ----------------------------------------------------------
  typedef enum logic [2:0] {
    op_umul = 3'd0,  // unsigned 32x32, high word to y
    op_smul = 3'd1,  // signed 32x32
    op_sll  = 3'd2,  // logical left
    op_srl  = 3'd3,  // logical right
    op_sra  = 3'd4,  // arithmetic right
    op_udiv = 3'd5,  // unsigned divide, remainder to y
    op_sdiv = 3'd6   // signed divide, overflow on min / -1
  } xalu_op_e;

  typedef logic [DATA_W-1:0] xalu_word_t;

  // ----------------------------------------------------------
  // result and request formats
  // ----------------------------------------------------------

  // result word as kept in the per-thread table, 67 bits
  typedef struct packed {
    xalu_word_t res;  // main result, quotient for divides
    xalu_word_t y;    // product high word or remainder
    logic       n;    // negative
    logic       z;    // zero
    logic       v;    // divide overflow
  } xalu_res_t;

  // queued request, one FIFO entry
  typedef struct packed {
    logic [TID_W-1:0] tid;  // issuing thread
    xalu_op_e         op;
    xalu_word_t       op1;
    xalu_word_t       op2;
  } xalu_req_t;

endpackage

`default_nettype wire

/* src/xalu_result_buf.sv */
// per-thread result table and ready bits
// writeback arbitration, mul has priority over div

`timescale 1ns/1ps
`default_nettype none

module xalu_result_buf #(
  parameter int NTHREAD = 8
) (
  input  bit                       gclk,
  input  bit                       rst,
  input  bit                       clr_en,   // new request, thread not ready
  input  bit [xalu_pkg::TID_W-1:0] clr_tid,
  input  bit                       mul_done,
  input  bit [xalu_pkg::TID_W-1:0] mul_tid,
  input  xalu_pkg::xalu_res_t      mul_res,
  input  bit                       div_done,
  input  bit [xalu_pkg::TID_W-1:0] div_tid,
  input  xalu_pkg::xalu_res_t      div_res,
  output bit                       div_ack,  // div write accepted this cycle
  input  bit [xalu_pkg::TID_W-1:0] rd_tid,
  output bit                       rd_ready,
  output xalu_pkg::xalu_res_t      rd_res
);

  xalu_pkg::xalu_res_t        res_mem [NTHREAD];  // one result per thread
  logic [NTHREAD-1:0]         ready;
  logic                       wr_en;
  logic [xalu_pkg::TID_W-1:0] wr_tid;
  xalu_pkg::xalu_res_t        wr_res;

  // ----------------------------------------------------------
  // write port arbitration
  // ----------------------------------------------------------
  assign div_ack = div_done && !mul_done;  // div waits behind mul
  assign wr_en   = mul_done || div_ack;
  assign wr_tid  = mul_done ? mul_tid : div_tid;
  assign wr_res  = mul_done ? mul_res : div_res;

  // combinational read for the top
  assign rd_ready = ready[rd_tid];
  assign rd_res   = res_mem[rd_tid];

  always_ff @(posedge gclk) begin
    if (wr_en) res_mem[wr_tid] <= wr_res;
  end

  // ready bits
  always_ff @(posedge gclk) begin
    if (rst) begin
      ready <= '0;
    end else begin
      if (clr_en) ready[clr_tid] <= 1'b0;
      if (wr_en)  ready[wr_tid]  <= 1'b1;
    end
  end

  // a thread issues again only after collecting, so no overlap
  a_clr_wr_tid : assert property (@(posedge gclk) disable iff (rst)
    !(clr_en && wr_en && (clr_tid == wr_tid)));

endmodule

`default_nettype wire

/* testbench/tb_xalu.sv */
// testbench for the extended alu front end
// reference model, falling-edge stimulus, one-cycle-late output checker

`timescale 1ns/1ps
`default_nettype none

module tb_xalu;

  localparam int NTHREAD = 8;
  localparam int W       = xalu_pkg::DATA_W;
  localparam int TW      = xalu_pkg::TID_W;
  localparam int MAX_TRY = 200;  // replay attempts per collect

  // what the checker expects for a given input cycle
  localparam int K_IDLE   = 0;
  localparam int K_NEW    = 1;
  localparam int K_REPLAY = 2;  // ready bit known in advance
  localparam int K_POLL   = 3;  // ready unknown, result checked once valid

  bit                   gclk, rst, in_valid, in_replay;
  bit [TW-1:0]          in_tid;
  xalu_pkg::xalu_op_e   in_op;
  xalu_pkg::xalu_word_t in_op1, in_op2;
  bit                   out_valid, out_divz, new_replay;
  xalu_pkg::xalu_res_t  out_res;

  int                   seed  = 65;
  int                   n_err = 0;
  xalu_pkg::xalu_res_t  exp_res [NTHREAD];  // expected result per thread
  bit                   pending [NTHREAD];  // issued, not yet collected
  bit                   seen_valid;         // out_valid of the last cycle

  int                   cur_kind = K_IDLE;
  int                   due_kind;
  bit [TW-1:0]          cur_tid, due_tid;
  bit                   cur_divz, due_divz, cur_ready, due_ready;
  xalu_pkg::xalu_res_t  due_res;

  xalu_if #(.NTHREAD(NTHREAD)) dut0 (
    .gclk(gclk), .rst(rst), .in_valid(in_valid), .in_replay(in_replay),
    .in_tid(in_tid), .in_op(in_op), .in_op1(in_op1), .in_op2(in_op2),
    .out_valid(out_valid), .out_divz(out_divz), .new_replay(new_replay),
    .out_res(out_res)
  );

  initial begin
    gclk = 1'b0;
    forever #5 gclk = ~gclk;  // 10 ns period
  end

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------
  function automatic xalu_pkg::xalu_res_t ref_xalu(input xalu_pkg::xalu_op_e op,
                                                   input xalu_pkg::xalu_word_t a,
                                                   input xalu_pkg::xalu_word_t b);
    xalu_pkg::xalu_res_t  r;
    logic [2*W-1:0]       p;
    xalu_pkg::xalu_word_t ma, mb, q, m, mn;
    int                   sh;
    r  = '0;
    sh = b % W;                       // shift amount from the low bits
    mn = {1'b1, {(W-1){1'b0}}};       // most negative number
    case (op)
      xalu_pkg::op_umul: begin
        p     = {{W{1'b0}}, a} * {{W{1'b0}}, b};
        r.res = p[W-1:0];
        r.y   = p[2*W-1:W];
      end
      xalu_pkg::op_smul: begin
        p     = {{W{a[W-1]}}, a} * {{W{b[W-1]}}, b};  // sign-extended, mod 2^64
        r.res = p[W-1:0];
        r.y   = p[2*W-1:W];
      end
      xalu_pkg::op_sll: r.res = a << sh;
      xalu_pkg::op_srl: r.res = a >> sh;
      xalu_pkg::op_sra: begin
        r.res = a >> sh;
        if (a[W-1]) r.res = r.res | ~({W{1'b1}} >> sh);  // sign fill
      end
      xalu_pkg::op_udiv: begin
        r.res = a / b;
        r.y   = a % b;
      end
      xalu_pkg::op_sdiv: begin
        if (a == mn && b == '1) begin
          r.res = mn;  // overflow case
          r.v   = 1'b1;
        end else begin
          ma    = a[W-1] ? -a : a;
          mb    = b[W-1] ? -b : b;
          q     = ma / mb;
          m     = ma % mb;
          r.res = (a[W-1] ^ b[W-1]) ? -q : q;
          r.y   = a[W-1] ? -m : m;  // remainder sign follows dividend
        end
      end
      default: ;
    endcase
    r.n = r.res[W-1];
    r.z = (r.res == '0);
    return r;
  endfunction

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_bit(input bit got, input bit exp, input string what);
    if (got !== exp) begin
      n_err++;
      $display("[FAIL] %0t ns: %s is %0b, expected %0b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_res(input xalu_pkg::xalu_res_t got, input xalu_pkg::xalu_res_t exp,
                           input int tid);
    if (got !== exp) begin
      n_err++;
      $display("[FAIL] %0t ns: thread %0d res %h y %h nzv %b%b%b, expected res %h y %h nzv %b%b%b",
               $time, tid, got.res, got.y, got.n, got.z, got.v,
               exp.res, exp.y, exp.n, exp.z, exp.v);
      abort_run();
    end
  endtask

  // expectation latched at the sampling edge, outputs compared at the next fall
  initial begin : compare
    forever begin
      @(posedge gclk);
      due_kind  = cur_kind;
      due_tid   = cur_tid;
      due_divz  = cur_divz;
      due_ready = cur_ready;
      due_res   = exp_res[cur_tid];
      @(negedge gclk);
      case (due_kind)
        K_IDLE: begin
          check_bit(out_valid, 1'b0, "out_valid on idle cycle");
          check_bit(out_divz, 1'b0, "out_divz on idle cycle");
          check_bit(new_replay, 1'b0, "new_replay on idle cycle");
        end
        K_NEW: begin
          check_bit(out_valid, 1'b0, "out_valid after new request");
          check_bit(out_divz, due_divz, "out_divz after new request");
          check_bit(new_replay, !due_divz, "new_replay after new request");
        end
        K_REPLAY: begin
          check_bit(out_valid, due_ready, "out_valid after replay");
          check_bit(out_divz, 1'b0, "out_divz after replay");
          check_bit(new_replay, !due_ready, "new_replay after replay");
          if (due_ready) check_res(out_res, due_res, due_tid);
        end
        default: begin  // poll
          check_bit(out_divz, 1'b0, "out_divz after poll");
          check_bit(new_replay, !out_valid, "new_replay after poll");
          if (out_valid) check_res(out_res, due_res, due_tid);
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // stimulus tasks, all driven on the falling edge
  // ----------------------------------------------------------
  task automatic drive_idle();
    @(negedge gclk);
    seen_valid = out_valid;  // outcome of the previous input cycle
    in_valid   = 1'b0;
    in_replay  = 1'b0;
    cur_kind   = K_IDLE;
  endtask

  task automatic send_op(input int tid, input xalu_pkg::xalu_op_e op,
                         input xalu_pkg::xalu_word_t a, input xalu_pkg::xalu_word_t b);
    bit divz;
    divz = (op == xalu_pkg::op_udiv || op == xalu_pkg::op_sdiv) && (b == '0);
    @(negedge gclk);
    in_valid  = 1'b1;
    in_replay = 1'b0;
    in_tid    = TW'(tid);
    in_op     = op;
    in_op1    = a;
    in_op2    = b;
    cur_kind  = K_NEW;
    cur_tid   = TW'(tid);
    cur_divz  = divz;
    if (!divz) begin
      exp_res[tid] = ref_xalu(op, a, b);
      pending[tid] = 1'b1;
    end
  endtask

  task automatic replay(input int tid, input int kind, input bit ready);
    @(negedge gclk);
    in_valid  = 1'b1;
    in_replay = 1'b1;
    in_tid    = TW'(tid);
    cur_kind  = kind;
    cur_tid   = TW'(tid);
    cur_ready = ready;
  endtask

  // replay until the thread's result shows up
  task automatic collect(input int tid);
    int tries;
    tries      = 0;
    seen_valid = 1'b0;
    while (!seen_valid) begin
      if (tries == MAX_TRY) begin
        $display("thread %0d: result never became ready within %0d replays", tid, MAX_TRY);
        abort_run();
      end else begin
        replay(tid, K_POLL, 1'b0);
        drive_idle();
        tries++;
      end
    end
    pending[tid] = 1'b0;
  endtask

  task automatic collect_all();
    for (int t = 0; t < NTHREAD; t++) begin
      if (pending[t]) collect(t);
    end
  endtask

  task automatic rand_divisor(output xalu_pkg::xalu_word_t b);
    b = $random(seed);
    if (b[0]) b = b >> ($unsigned($random(seed)) % W);  // small divisors too
    if (b == '0) b = 1;
  endtask

  // ----------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------
  initial begin : stimulus
    xalu_pkg::xalu_word_t a, b;
    xalu_pkg::xalu_op_e   op;
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_replay = 1'b0;
    in_tid    = '0;
    in_op     = xalu_pkg::op_umul;
    in_op1    = '0;
    in_op2    = '0;
    repeat (16) @(negedge gclk);
    rst = 1'b0;
    drive_idle();

    // nothing ready after reset
    for (int t = 0; t < NTHREAD; t++) replay(t, K_REPLAY, 1'b0);
    drive_idle();

    // multiply and shift on all threads
    repeat (4) begin
      for (int t = 0; t < NTHREAD; t++) begin
        op = xalu_pkg::xalu_op_e'($unsigned($random(seed)) % 5);
        a  = $random(seed);
        b  = $random(seed);
        send_op(t, op, a, b);
      end
      collect_all();
    end

    // divide corner cases, then random divides
    send_op(0, xalu_pkg::op_sdiv, {1'b1, {(W-1){1'b0}}}, '1);
    send_op(1, xalu_pkg::op_sdiv, -32'd7, 32'd2);
    send_op(2, xalu_pkg::op_sdiv, 32'd7, -32'd2);
    send_op(3, xalu_pkg::op_sdiv, -32'd7, -32'd2);
    send_op(4, xalu_pkg::op_udiv, '1, 32'd3);
    send_op(5, xalu_pkg::op_sdiv, {1'b1, {(W-1){1'b0}}}, 32'd1);
    send_op(6, xalu_pkg::op_udiv, 32'd5, 32'd9);
    send_op(7, xalu_pkg::op_sdiv, -32'd100, 32'd7);
    collect_all();
    repeat (2) begin
      for (int t = 0; t < NTHREAD; t++) begin
        op = $random(seed) & 1 ? xalu_pkg::op_sdiv : xalu_pkg::op_udiv;
        a  = $random(seed);
        rand_divisor(b);
        send_op(t, op, a, b);
      end
      collect_all();
    end

    // divide by zero is flagged and never becomes ready
    send_op(2, xalu_pkg::op_sdiv, $random(seed), '0);
    replay(2, K_REPLAY, 1'b0);
    send_op(5, xalu_pkg::op_udiv, $random(seed), '0);
    drive_idle();
    replay(5, K_REPLAY, 1'b0);
    drive_idle();

    // mixed round robin over all threads
    repeat (4) begin
      for (int t = 0; t < NTHREAD; t++) begin
        op = xalu_pkg::xalu_op_e'($unsigned($random(seed)) % 7);
        a  = $random(seed);
        if (op == xalu_pkg::op_udiv || op == xalu_pkg::op_sdiv)
          rand_divisor(b);
        else
          b = $random(seed);
        send_op(t, op, a, b);
      end
      collect_all();
    end

    // divider finishes while mul results stream in, its writeback waits
    repeat (2) begin
      rand_divisor(b);
      send_op(0, xalu_pkg::op_sdiv, $random(seed), b);
      repeat (W - 4) drive_idle();  // muls land around the divider's done cycle
      for (int t = 1; t < NTHREAD; t++) begin
        op = xalu_pkg::xalu_op_e'($unsigned($random(seed)) % 5);
        send_op(t, op, $random(seed), $random(seed));
      end
      collect_all();
    end

    // a new request clears the old ready bit
    for (int t = 1; t < NTHREAD; t += 3) begin
      send_op(t, xalu_pkg::op_smul, $random(seed), $random(seed));
      collect(t);
      rand_divisor(b);
      send_op(t, xalu_pkg::op_sdiv, $random(seed), b);
      replay(t, K_REPLAY, 1'b0);
      replay(t, K_REPLAY, 1'b0);
      collect(t);
    end

    repeat (4) drive_idle();
    if (n_err == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

`default_nettype wire

/* verilog.f */
src/xalu_pkg.sv
src/xalu_in_fifo.sv
src/xalu_mul_shf.sv
src/xalu_div.sv
src/xalu_result_buf.sv
src/xalu_if.sv
testbench/tb_xalu.sv
